//--- pinballScene.f
+incdir+design
design/pinballGeomPkg.sv
design/pinballHitPkg.sv
design/scanTimer.sv
design/sceneLayout.sv
design/sceneRenderer.sv
design/collisionDetector.sv
design/pinballScene.sv
dv/pinballScene_checker.sv
dv/pinballSceneTb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := pinballSceneTb
FILELIST := pinballScene.f
SIMARGS  := +verilator+error+limit+1000
PASS     := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS)"

clean:
	rm -rf obj_dir

//--- dv/pinballSceneTb.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module pinballSceneTb import pinballGeomPkg::*, pinballHitPkg::*; ();

	localparam int clkPeriod      = 40;
	localparam int frameClocks    = `SCAN_WIDTH * `SCAN_HEIGHT;
	localparam int watchdogClocks = 12 * frameClocks;
	localparam pixelCoord lastCol  = pixelCoord'(`SCAN_WIDTH - 1);
	localparam pixelCoord lastRow  = pixelCoord'(`SCAN_HEIGHT - 1);
	localparam pixelCoord bandEnd  = pixelCoord'(`BORDER_THICK);
	localparam pixelCoord rightBand  = pixelCoord'(`SCAN_WIDTH - `BORDER_THICK);
	localparam pixelCoord bottomBand = pixelCoord'(`SCAN_HEIGHT - `BORDER_THICK);

	logic      clk;
	logic      resetN;
	logic      layoutWrite;
	objectId   layoutObject;
	rectField  layoutField;
	pixelCoord layoutData;
	pixelCoord pixelX;
	pixelCoord pixelY;
	logic      frameStart;
	hitFlags   hits;

	int seed;
	int timingErrors;
	int levelErrors;
	int eventErrors;
	int stickyErrors;

	// reference copy of scan position and layout
	pixelCoord  scanRefX;
	pixelCoord  scanRefY;
	pixelCoord  outX;
	pixelCoord  outY;
	logic       outValid;
	logic       outFrameStart;
	sceneRects  shadowRef;
	sceneRects  activeRef;
	sceneRects  usedRects; // layout seen by the pixel on the outputs
	logic [2:0] seenRef;   // obstacle, spring, bumper
	logic [1:0] stickyRef; // flipper left, right
	logic [2:0] contactRef;
	logic [2:0] firstRef;
	drawFlags   expDraw;
	hitFlags    expHits;

	logic [5:0] levelBits;
	logic [5:0] expLevelBits;
	logic [4:0] eventBits;
	logic [4:0] expEventBits;

	pinballScene DUT (
		.clk          (clk),
		.resetN       (resetN),
		.layoutWrite  (layoutWrite),
		.layoutObject (layoutObject),
		.layoutField  (layoutField),
		.layoutData   (layoutData),
		.pixelX       (pixelX),
		.pixelY       (pixelY),
		.frameStart   (frameStart),
		.hits         (hits)
	);

	bind collisionDetector pinballScene_checker frameRules (
		.clk    (clk),
		.resetN (resetN),
		.draw   (draw),
		.hits   (hits)
	);

	function automatic logic covers(objRect r, pixelCoord x, pixelCoord y);
		return (x >= r.left) && (x <= r.right) && (y >= r.top) && (y <= r.bottom);
	endfunction

	function automatic drawFlags coverage(sceneRects r, pixelCoord x, pixelCoord y);
		drawFlags d;
		d.ball         = covers(r[objBall], x, y);
		d.borderTop    = (y < bandEnd);
		d.borderBottom = (y >= bottomBand);
		d.borderLeft   = (x < bandEnd);
		d.borderRight  = (x >= rightBand);
		d.frame        = covers(r[objFrame], x, y);
		d.flipper      = covers(r[objFlipper], x, y);
		d.obstacle     = covers(r[objObstacle], x, y);
		d.spring       = covers(r[objSpring], x, y);
		d.bumper       = covers(r[objBumper], x, y);
		d.scoreNumber  = covers(r[objScoreNumber], x, y);
		d.frameStart   = 1'b0;
		return d;
	endfunction

	function automatic objRect withField(objRect r, rectField f, pixelCoord v);
		objRect n;
		n = r;
		case (f)
			fieldLeft:  n.left   = v;
			fieldTop:   n.top    = v;
			fieldRight: n.right  = v;
			default:    n.bottom = v;
		endcase
		return n;
	endfunction

	always_comb begin
		expDraw = outValid ? coverage(usedRects, outX, outY) : '0;
		expDraw.frameStart = outValid && outFrameStart;
		contactRef = {
			expDraw.ball && expDraw.obstacle,
			expDraw.ball && expDraw.spring,
			expDraw.ball && expDraw.bumper
		};
		firstRef = contactRef & (expDraw.frameStart ? 3'b111 : ~seenRef); // new frame forgets
		expHits.ballBorderTop      = expDraw.ball && expDraw.borderTop;
		expHits.ballBorderBottom   = expDraw.ball && expDraw.borderBottom;
		expHits.ballBorderLeft     = expDraw.ball && expDraw.borderLeft;
		expHits.ballBorderRight    = expDraw.ball && expDraw.borderRight;
		expHits.ballFrame          = expDraw.ball && expDraw.frame;
		expHits.ballFlipper        = expDraw.ball && expDraw.flipper;
		expHits.flipperBorderLeft  = stickyRef[1];
		expHits.flipperBorderRight = stickyRef[0];
		expHits.ballObstacle       = firstRef[2];
		expHits.ballObstacleGood   = firstRef[2] && expDraw.scoreNumber;
		expHits.ballObstacleBad    = firstRef[2] && !expDraw.scoreNumber;
		expHits.ballSpringPulse    = firstRef[1];
		expHits.ballBumperPulse    = firstRef[0];
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			scanRefX      <= '0;
			scanRefY      <= '0;
			outX          <= '0;
			outY          <= '0;
			outValid      <= 1'b0;
			outFrameStart <= 1'b0;
			shadowRef     <= '0;
			activeRef     <= '0;
			usedRects     <= '0;
			seenRef       <= '0;
			stickyRef     <= '0;
		end else begin
			outValid      <= 1'b1;
			outX          <= scanRefX;
			outY          <= scanRefY;
			outFrameStart <= (scanRefX == '0) && (scanRefY == '0);
			usedRects     <= activeRef;
			if ((scanRefX == '0) && (scanRefY == '0)) begin
				activeRef <= shadowRef; // commit at frame start
			end
			if (layoutWrite) begin
				shadowRef[layoutObject] <= withField(shadowRef[layoutObject], layoutField,
					layoutData);
			end
			scanRefX <= (scanRefX == lastCol) ? '0 : scanRefX + 1'b1;
			if (scanRefX == lastCol) begin
				scanRefY <= (scanRefY == lastRow) ? '0 : scanRefY + 1'b1;
			end
			seenRef <= expDraw.frameStart ? contactRef : (seenRef | contactRef);
			stickyRef <= expDraw.frameStart ? 2'b00 : (stickyRef | {
				expDraw.flipper && expDraw.borderLeft,
				expDraw.flipper && expDraw.borderRight
			});
		end
	end

	assign levelBits = {hits.ballBorderTop, hits.ballBorderBottom, hits.ballBorderLeft,
		hits.ballBorderRight, hits.ballFrame, hits.ballFlipper};
	assign expLevelBits = {expHits.ballBorderTop, expHits.ballBorderBottom,
		expHits.ballBorderLeft, expHits.ballBorderRight, expHits.ballFrame, expHits.ballFlipper};
	assign eventBits = {hits.ballObstacle, hits.ballObstacleGood, hits.ballObstacleBad,
		hits.ballSpringPulse, hits.ballBumperPulse};
	assign expEventBits = {expHits.ballObstacle, expHits.ballObstacleGood,
		expHits.ballObstacleBad, expHits.ballSpringPulse, expHits.ballBumperPulse};

	resetQuiet: assert property (@(posedge clk) !resetN |-> (hits == '0) && !frameStart)
		else begin
			$display("error reset: expected %h, actual %h", 14'h0, $sampled({hits, frameStart}));
			timingErrors++;
		end

	pixelPosition: assert property (@(posedge clk) disable iff (!resetN)
		{pixelX, pixelY} == {outX, outY})
		else begin
			$display("error pixel: expected %h, actual %h", $sampled({outX, outY}),
				$sampled({pixelX, pixelY}));
			timingErrors++;
		end

	frameStrobe: assert property (@(posedge clk) disable iff (!resetN)
		frameStart == expDraw.frameStart)
		else begin
			$display("error frameStart: expected %b, actual %b", $sampled(expDraw.frameStart),
				$sampled(frameStart));
			timingErrors++;
		end

	levelHits: assert property (@(posedge clk) disable iff (!resetN) levelBits == expLevelBits)
		else begin
			$display("error levels: expected %b, actual %b", $sampled(expLevelBits),
				$sampled(levelBits));
			levelErrors++;
		end

	firstHits: assert property (@(posedge clk) disable iff (!resetN) eventBits == expEventBits)
		else begin
			$display("error events: expected %b, actual %b", $sampled(expEventBits),
				$sampled(eventBits));
			eventErrors++;
		end

	stickyHits: assert property (@(posedge clk) disable iff (!resetN)
		{hits.flipperBorderLeft, hits.flipperBorderRight} == stickyRef)
		else begin
			$display("error sticky: expected %b, actual %b", $sampled(stickyRef),
				$sampled({hits.flipperBorderLeft, hits.flipperBorderRight}));
			stickyErrors++;
		end

	task automatic writeField(input objectId id, input rectField field, input pixelCoord data);
		@(posedge clk);
		layoutWrite  <= 1'b1;
		layoutObject <= id;
		layoutField  <= field;
		layoutData   <= data;
		@(posedge clk);
		layoutWrite  <= 1'b0;
	endtask

	task automatic writeRect(input objectId id, input pixelCoord l, t, r, b);
		writeField(id, fieldLeft, l);
		writeField(id, fieldTop, t);
		writeField(id, fieldRight, r);
		writeField(id, fieldBottom, b);
	endtask

	task automatic randomRect(input objectId id);
		pixelCoord l;
		pixelCoord t;
		pixelCoord w;
		pixelCoord h;
		l = pixelCoord'($unsigned($random(seed)) % 60);
		t = pixelCoord'($unsigned($random(seed)) % 40);
		w = pixelCoord'($unsigned($random(seed)) % 20);
		h = pixelCoord'($unsigned($random(seed)) % 16);
		writeRect(id, l, t, l + w, t + h);
	endtask

	task automatic waitFrames(input int count);
		repeat (count) begin
			@(posedge clk);
			while (!frameStart) begin
				@(posedge clk);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(watchdogClocks * clkPeriod);
		$display("timeout: the scan did not finish its frames in time");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int total;
		resetN       = 1'b0;
		layoutWrite  = 1'b0;
		layoutObject = objBall;
		layoutField  = fieldLeft;
		layoutData   = '0;
		seed         = 32'hd8a4_924e;
		timingErrors = 0;
		levelErrors  = 0;
		eventErrors  = 0;
		stickyErrors = 0;
		repeat (10) @(posedge clk);
		resetN <= 1'b1;

		// ball across top and left bands, score digit on the first obstacle pixel
		writeRect(objBall, 7'd2, 7'd2, 7'd12, 7'd9);
		writeRect(objFrame, 7'd8, 7'd0, 7'd20, 7'd5);
		writeRect(objFlipper, 7'd0, 7'd40, 7'd45, 7'd44); // reaches into the left band
		writeRect(objObstacle, 7'd10, 7'd6, 7'd16, 7'd12);
		writeRect(objSpring, 7'd5, 7'd8, 7'd7, 7'd20);
		writeRect(objBumper, 7'd12, 7'd3, 7'd14, 7'd4);
		writeRect(objScoreNumber, 7'd9, 7'd5, 7'd11, 7'd7);
		waitFrames(2);

		// bad obstacle hit, flipper into the right band
		writeRect(objScoreNumber, 7'd60, 7'd30, 7'd70, 7'd34);
		writeRect(objFlipper, 7'd70, 7'd20, 7'd79, 7'd26);
		waitFrames(2);

		// ball move mid-frame, down into the bottom band
		repeat (frameClocks / 2) @(posedge clk);
		writeRect(objBall, 7'd68, 7'd18, 7'd78, 7'd54);
		waitFrames(1);

		for (int round = 0; round < 2; round++) begin
			for (int obj = 0; obj < 7; obj++) begin
				randomRect(objectId'(obj));
			end
			waitFrames(1);
		end
		waitFrames(1);

		@(posedge clk);
		total = timingErrors + levelErrors + eventErrors + stickyErrors +
			DUT.detector.frameRules.failCount;
		$display("errors: timing %0d, levels %0d, events %0d, sticky %0d, checker %0d",
			timingErrors, levelErrors, eventErrors, stickyErrors,
			DUT.detector.frameRules.failCount);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- dv/pinballScene_checker.sv
`timescale 1ns/1ps

module pinballScene_checker import pinballHitPkg::*; (
	input logic     clk,
	input logic     resetN,
	input drawFlags draw,
	input hitFlags  hits
);

	int failCount = 0; // read by the testbench

	// pulses already seen in the running frame
	logic obstacleFired;
	logic springFired;
	logic bumperFired;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			obstacleFired <= 1'b0;
			springFired   <= 1'b0;
			bumperFired   <= 1'b0;
		end else if (draw.frameStart) begin
			obstacleFired <= hits.ballObstacle;
			springFired   <= hits.ballSpringPulse;
			bumperFired   <= hits.ballBumperPulse;
		end else begin
			obstacleFired <= obstacleFired | hits.ballObstacle;
			springFired   <= springFired | hits.ballSpringPulse;
			bumperFired   <= bumperFired | hits.ballBumperPulse;
		end
	end

	obstacleOnce: assert property (@(posedge clk) disable iff (!resetN)
		hits.ballObstacle && !draw.frameStart |-> !obstacleFired)
		else begin
			$error("obstacle hit fired twice in one frame");
			failCount++;
		end

	springOnce: assert property (@(posedge clk) disable iff (!resetN)
		hits.ballSpringPulse && !draw.frameStart |-> !springFired)
		else begin
			$error("spring pulse fired twice in one frame");
			failCount++;
		end

	bumperOnce: assert property (@(posedge clk) disable iff (!resetN)
		hits.ballBumperPulse && !draw.frameStart |-> !bumperFired)
		else begin
			$error("bumper pulse fired twice in one frame");
			failCount++;
		end

	goodOrBad: assert property (@(posedge clk) disable iff (!resetN)
		!(hits.ballObstacleGood && hits.ballObstacleBad))
		else begin
			$error("obstacle hit is good and bad at once");
			failCount++;
		end

	stickyCleared: assert property (@(posedge clk) disable iff (!resetN)
		draw.frameStart |=> !hits.flipperBorderLeft && !hits.flipperBorderRight)
		else begin
			$error("flipper border flag still high after frame start");
			failCount++;
		end

endmodule

//--- design/pinballScene.sv
`timescale 1ns/1ps

module pinballScene import pinballGeomPkg::*, pinballHitPkg::*; (
	input  logic      clk,
	input  logic      resetN,
	input  logic      layoutWrite,
	input  objectId   layoutObject,
	input  rectField  layoutField,
	input  pixelCoord layoutData,
	output pixelCoord pixelX,
	output pixelCoord pixelY,
	output logic      frameStart,
	output hitFlags   hits
);

	pixelCoord scanX;
	pixelCoord scanY;
	logic      startOfFrame;
	sceneRects activeRects;
	drawFlags  draw;

	scanTimer timer (
		.clk          (clk),
		.resetN       (resetN),
		.scanX        (scanX),
		.scanY        (scanY),
		.startOfFrame (startOfFrame)
	);

	sceneLayout layout (
		.clk          (clk),
		.resetN       (resetN),
		.startOfFrame (startOfFrame),
		.layoutWrite  (layoutWrite),
		.layoutObject (layoutObject),
		.layoutField  (layoutField),
		.layoutData   (layoutData),
		.activeRects  (activeRects)
	);

	sceneRenderer renderer (
		.clk          (clk),
		.resetN       (resetN),
		.scanX        (scanX),
		.scanY        (scanY),
		.startOfFrame (startOfFrame),
		.activeRects  (activeRects),
		.draw         (draw),
		.drawX        (pixelX),
		.drawY        (pixelY)
	);

	collisionDetector detector (
		.clk    (clk),
		.resetN (resetN),
		.draw   (draw),
		.hits   (hits)
	);

	assign frameStart = draw.frameStart; // aligned with hits

endmodule

//--- design/collisionDetector.sv
`timescale 1ns/1ps

module collisionDetector import pinballHitPkg::*; (
	input  logic     clk,
	input  logic     resetN,
	input  drawFlags draw,
	output hitFlags  hits
);

	// first-contact events: obstacle, spring, bumper
	logic [2:0] contact;
	logic [2:0] contactSeen;
	logic [2:0] firstContact;

	// sticky flipper-border flags: left, right
	logic [1:0] flipperBorder;
	logic [1:0] flipperSticky;

	assign contact = {
		draw.ball && draw.obstacle,
		draw.ball && draw.spring,
		draw.ball && draw.bumper
	};

	// the frameStart pixel already belongs to the new frame
	assign firstContact = contact & (draw.frameStart ? 3'b111 : ~contactSeen);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			contactSeen <= '0;
		end else if (draw.frameStart) begin
			contactSeen <= contact;
		end else begin
			contactSeen <= contactSeen | contact;
		end
	end

	assign flipperBorder = {
		draw.flipper && draw.borderLeft,
		draw.flipper && draw.borderRight
	};

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			flipperSticky <= '0;
		end else if (draw.frameStart) begin
			flipperSticky <= '0; // cleared for the new frame
		end else begin
			flipperSticky <= flipperSticky | flipperBorder;
		end
	end

	always_comb begin
		hits.ballBorderTop      = draw.ball && draw.borderTop;
		hits.ballBorderBottom   = draw.ball && draw.borderBottom;
		hits.ballBorderLeft     = draw.ball && draw.borderLeft;
		hits.ballBorderRight    = draw.ball && draw.borderRight;
		hits.ballFrame          = draw.ball && draw.frame;
		hits.ballFlipper        = draw.ball && draw.flipper;
		hits.flipperBorderLeft  = flipperSticky[1];
		hits.flipperBorderRight = flipperSticky[0];
		hits.ballObstacle       = firstContact[2];
		hits.ballObstacleGood   = firstContact[2] && draw.scoreNumber; // hit on the score digit
		hits.ballObstacleBad    = firstContact[2] && !draw.scoreNumber;
		hits.ballSpringPulse    = firstContact[1];
		hits.ballBumperPulse    = firstContact[0];
	end

endmodule

//--- design/sceneRenderer.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module sceneRenderer import pinballGeomPkg::*, pinballHitPkg::*; (
	input  logic      clk,
	input  logic      resetN,
	input  pixelCoord scanX,
	input  pixelCoord scanY,
	input  logic      startOfFrame,
	input  sceneRects activeRects,
	output drawFlags  draw,
	output pixelCoord drawX,
	output pixelCoord drawY
);

	localparam pixelCoord bandEnd     = pixelCoord'(`BORDER_THICK);
	localparam pixelCoord rightStart  = pixelCoord'(`SCAN_WIDTH - `BORDER_THICK);
	localparam pixelCoord bottomStart = pixelCoord'(`SCAN_HEIGHT - `BORDER_THICK);

	drawFlags drawNext;

	function automatic logic inRect(objRect r, pixelCoord x, pixelCoord y);
		logic inX;
		logic inY;
		inX = (x >= r.left) && (x <= r.right);
		inY = (y >= r.top) && (y <= r.bottom);
		return inX && inY;
	endfunction

	always_comb begin
		drawNext.ball         = inRect(activeRects[objBall], scanX, scanY);
		drawNext.borderTop    = (scanY < bandEnd);
		drawNext.borderBottom = (scanY >= bottomStart);
		drawNext.borderLeft   = (scanX < bandEnd);
		drawNext.borderRight  = (scanX >= rightStart);
		drawNext.frame        = inRect(activeRects[objFrame], scanX, scanY);
		drawNext.flipper      = inRect(activeRects[objFlipper], scanX, scanY);
		drawNext.obstacle     = inRect(activeRects[objObstacle], scanX, scanY);
		drawNext.spring       = inRect(activeRects[objSpring], scanX, scanY);
		drawNext.bumper       = inRect(activeRects[objBumper], scanX, scanY);
		drawNext.scoreNumber  = inRect(activeRects[objScoreNumber], scanX, scanY);
		drawNext.frameStart   = startOfFrame;
	end

	// one clock of latency, coordinate travels with the flags
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			draw  <= '0;
			drawX <= '0;
			drawY <= '0;
		end else begin
			draw  <= drawNext;
			drawX <= scanX;
			drawY <= scanY;
		end
	end

endmodule

//--- design/sceneLayout.sv
`timescale 1ns/1ps

module sceneLayout import pinballGeomPkg::*; (
	input  logic      clk,
	input  logic      resetN,
	input  logic      startOfFrame,
	input  logic      layoutWrite,
	input  objectId   layoutObject,
	input  rectField  layoutField,
	input  pixelCoord layoutData,
	output sceneRects activeRects
);

	sceneRects shadowRects;

	// field writes land in the shadow copy
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			shadowRects <= '0;
		end else if (layoutWrite) begin
			case (layoutField)
				fieldLeft:  shadowRects[layoutObject].left   <= layoutData;
				fieldTop:   shadowRects[layoutObject].top    <= layoutData;
				fieldRight: shadowRects[layoutObject].right  <= layoutData;
				default:    shadowRects[layoutObject].bottom <= layoutData;
			endcase
		end
	end

	// Whole scene switches at once, so no object tears mid-frame.
	// A write in the commit clock only reaches the shadow copy.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			activeRects <= '0;
		end else if (startOfFrame) begin
			activeRects <= shadowRects;
		end
	end

endmodule

//--- design/scanTimer.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module scanTimer import pinballGeomPkg::*; (
	input  logic      clk,
	input  logic      resetN,
	output pixelCoord scanX,
	output pixelCoord scanY,
	output logic      startOfFrame
);

	localparam pixelCoord lastCol = pixelCoord'(`SCAN_WIDTH - 1);
	localparam pixelCoord lastRow = pixelCoord'(`SCAN_HEIGHT - 1);

	logic endOfLine;
	logic endOfFrame;

	assign endOfLine  = (scanX == lastCol);
	assign endOfFrame = endOfLine && (scanY == lastRow);

	// column counter
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			scanX <= '0;
		end else if (endOfLine) begin
			scanX <= '0;
		end else begin
			scanX <= scanX + 1'b1;
		end
	end

	// row counter, steps at end of each line
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			scanY <= '0;
		end else if (endOfFrame) begin
			scanY <= '0;
		end else if (endOfLine) begin
			scanY <= scanY + 1'b1;
		end
	end

	assign startOfFrame = (scanX == '0) && (scanY == '0); // one clock per frame

endmodule

//--- design/pinballHitPkg.sv
package pinballHitPkg;

	// coverage of one pixel, one bit per object
	typedef struct packed {
		logic ball;
		logic borderTop;
		logic borderBottom;
		logic borderLeft;
		logic borderRight;
		logic frame;
		logic flipper;
		logic obstacle;
		logic spring;
		logic bumper;
		logic scoreNumber;
		logic frameStart;
	} drawFlags;

	typedef struct packed {
		logic ballBorderTop;
		logic ballBorderBottom;
		logic ballBorderLeft;
		logic ballBorderRight;
		logic ballFrame;
		logic ballFlipper;
		logic flipperBorderLeft;
		logic flipperBorderRight;
		logic ballObstacle;
		logic ballObstacleGood;
		logic ballObstacleBad;
		logic ballSpringPulse;
		logic ballBumperPulse;
	} hitFlags;

endpackage

//--- design/pinballGeomPkg.sv
`include "pinball_macros.svh"

package pinballGeomPkg;

	typedef logic [`COORD_BITS-1:0] pixelCoord;

	// inclusive bounds on all four sides
	typedef struct packed {
		pixelCoord left;
		pixelCoord top;
		pixelCoord right;
		pixelCoord bottom;
	} objRect;

	typedef enum logic [2:0] {
		objBall        = 3'd0,
		objFrame       = 3'd1,
		objFlipper     = 3'd2,
		objObstacle    = 3'd3,
		objSpring      = 3'd4,
		objBumper      = 3'd5,
		objScoreNumber = 3'd6
	} objectId;

	typedef logic [1:0] rectField;

	localparam rectField fieldLeft   = 2'd0;
	localparam rectField fieldTop    = 2'd1;
	localparam rectField fieldRight  = 2'd2;
	localparam rectField fieldBottom = 2'd3;

	typedef objRect [6:0] sceneRects; // indexed by objectId

endpackage

//--- design/pinball_macros.svh
`ifndef PINBALL_MACROS_SVH
`define PINBALL_MACROS_SVH

// reduced raster, one pixel per clock
`define SCAN_WIDTH 80
`define SCAN_HEIGHT 56

// fixed border bands at the four raster edges
`define BORDER_THICK 4

// wide enough for any column or row of the raster
`define COORD_BITS 7

`endif
